// File: Makefile
TOOL     = verilator
TOP      = tb_hss_mux
FILELIST = list.f
FLAGS    = --binary --timing --assert -j 0 --top-module $(TOP)
LINT     = --lint-only --timing -Wall --top-module $(TOP)
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Test failed
PASS_MSG = Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAILED"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "FAILED"; exit 1)

lint:
	$(TOOL) $(LINT) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: frame_fifo.sv
`timescale 1ns/1ns

module frame_fifo
  import mux_link_pkg::*;
#(
  parameter int FIFO_DEPTH = 8
)
(
  input  logic                  clk_i
, input  logic                  rst_n_i
  // Write side
, input  link_word_u            wr_data_i
, input  logic [LINK_BYTES-1:0] wr_kflags_i
, input  logic                  wr_vld_i
, output logic                  wr_rdy_o
  // Read side
, output link_word_u            rd_data_o
, output logic [LINK_BYTES-1:0] rd_kflags_o
, output logic                  rd_vld_o
, input  logic                  rd_rdy_i
);

  localparam int PTR_BITS = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);

  link_word_u            mem_data   [FIFO_DEPTH];
  logic [LINK_BYTES-1:0] mem_kflags [FIFO_DEPTH];
  logic [PTR_BITS-1:0]   wr_ptr_q;
  logic [PTR_BITS-1:0]   rd_ptr_q;
  logic [CNT_BITS-1:0]   count_q;
  logic                  do_wr;
  logic                  do_rd;

  // Pointer step with wrap at the last slot
  function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] ptr);
    if (ptr == PTR_BITS'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign wr_rdy_o = (count_q != CNT_BITS'(FIFO_DEPTH));
  assign rd_vld_o = (count_q != '0);
  assign do_wr    = wr_vld_i && wr_rdy_o;
  assign do_rd    = rd_vld_o && rd_rdy_i;

  assign rd_data_o   = mem_data[rd_ptr_q];
  assign rd_kflags_o = mem_kflags[rd_ptr_q];

  // Word and flags stored side by side
  always_ff @(posedge clk_i) begin
    if (do_wr) begin
      mem_data[wr_ptr_q]   <= wr_data_i;
      mem_kflags[wr_ptr_q] <= wr_kflags_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_rd) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({do_wr, do_rd})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// File: hss_mux_sva.sv
`timescale 1ns/1ns

module hss_mux_sva
  import mux_pkt_pkg::*;
  import mux_link_pkg::*;
#(
  parameter int NUM_CHANS   = 4
, parameter int FIFO_DEPTH  = 8
, parameter int CC_INTERVAL = 64
)
(
  input logic                               clk_i
, input logic                               rst_n_i
, input logic [NUM_CHANS-1:0][PKT_BITS-1:0] pkt_data_i
, input logic [NUM_CHANS-1:0]               pkt_vld_i
, input logic [NUM_CHANS-1:0]               pkt_rdy_o
, input logic [LINK_BITS-1:0]               txdata_o
, input logic [LINK_BYTES-1:0]              txcharisk_o
);

  logic        is_cc;
  logic        is_hdr;
  logic        is_pay;
  logic        hdr_open_q;
  logic [31:0] acc_q;
  logic [31:0] pay_q;

  assign is_cc  = (txcharisk_o == CTRL_KFLAGS) && (txdata_o[7:0] == K_CC);
  assign is_hdr = (txcharisk_o == CTRL_KFLAGS) && (txdata_o[7:0] == K_SOF);
  assign is_pay = (txcharisk_o == '0);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hdr_open_q <= 1'b0;
      acc_q      <= '0;
      pay_q      <= '0;
    end else begin
      if (is_hdr) begin
        hdr_open_q <= 1'b1;
      end else if (is_pay) begin
        hdr_open_q <= 1'b0;
      end
      acc_q <= acc_q + 32'($countones(pkt_vld_i & pkt_rdy_o));
      pay_q <= pay_q + 32'(is_pay);
    end
  end

  a_one_rdy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(pkt_rdy_o))
    else $error("more than one stream ready");

  a_idle_rst: assert property (@(posedge clk_i) $rose(rst_n_i) |->
      txcharisk_o == CTRL_KFLAGS && txdata_o == {IDLE_FILL, K_COMMA})
    else $error("link not idle at reset release");

  a_cc_period: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      is_cc |=> (!is_cc) [*CC_INTERVAL-1] ##1 is_cc)
    else $error("clock correction off schedule");

  a_pay_after_hdr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      is_pay |-> hdr_open_q)
    else $error("payload not preceded by header");

  // Assembler frame plus FIFO_DEPTH/2 frames in the FIFO
  a_backpressure: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      acc_q <= pay_q + 32'(is_pay) + 32'(FIFO_DEPTH / 2 + 1))
    else $error("accepted packets outrun link capacity");

  for (genvar c = 0; c < NUM_CHANS; c++) begin : g_chan
    a_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pkt_vld_i[c] && !pkt_rdy_o[c] |=> pkt_vld_i[c] && $stable(pkt_data_i[c]))
      else $error("stream %0d changed before handshake", c);
  end

endmodule

bind hss_mux_top hss_mux_sva #(
  .NUM_CHANS   (NUM_CHANS)
, .FIFO_DEPTH  (FIFO_DEPTH)
, .CC_INTERVAL (CC_INTERVAL)
) u_hss_mux_sva (
  .clk_i       (clk_i)
, .rst_n_i     (rst_n_i)
, .pkt_data_i  (pkt_data_i)
, .pkt_vld_i   (pkt_vld_i)
, .pkt_rdy_o   (pkt_rdy_o)
, .txdata_o    (txdata_o)
, .txcharisk_o (txcharisk_o)
);

// File: hss_mux_top.sv
`timescale 1ns/1ns

module hss_mux_top
  import mux_pkt_pkg::*;
  import mux_link_pkg::*;
#(
  parameter int NUM_CHANS   = 4
, parameter int FIFO_DEPTH  = 8
  // Cycles between clock-correction words
, parameter int CC_INTERVAL = 64
)
(
  input  logic                               clk_i
, input  logic                               rst_n_i
  // Packet streams in
, input  logic [NUM_CHANS-1:0][PKT_BITS-1:0] pkt_data_i
, input  logic [NUM_CHANS-1:0]               pkt_vld_i
, output logic [NUM_CHANS-1:0]               pkt_rdy_o
  // Serial link out
, output logic [LINK_BITS-1:0]               txdata_o
, output logic [LINK_BYTES-1:0]              txcharisk_o
);

  // Assembler to FIFO
  link_word_u            wr_data;
  logic [LINK_BYTES-1:0] wr_kflags;
  logic                  wr_vld;
  logic                  wr_rdy;

  // FIFO to transmitter
  link_word_u            rd_data;
  logic [LINK_BYTES-1:0] rd_kflags;
  logic                  rd_vld;
  logic                  rd_rdy;

  pkt_assembler #(
    .NUM_CHANS (NUM_CHANS)
  ) u_pkt_assembler (
    .clk_i       (clk_i)
  , .rst_n_i     (rst_n_i)
  , .pkt_data_i  (pkt_data_i)
  , .pkt_vld_i   (pkt_vld_i)
  , .pkt_rdy_o   (pkt_rdy_o)
  , .wr_data_o   (wr_data)
  , .wr_kflags_o (wr_kflags)
  , .wr_vld_o    (wr_vld)
  , .wr_rdy_i    (wr_rdy)
  );

  frame_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_frame_fifo (
    .clk_i       (clk_i)
  , .rst_n_i     (rst_n_i)
  , .wr_data_i   (wr_data)
  , .wr_kflags_i (wr_kflags)
  , .wr_vld_i    (wr_vld)
  , .wr_rdy_o    (wr_rdy)
  , .rd_data_o   (rd_data)
  , .rd_kflags_o (rd_kflags)
  , .rd_vld_o    (rd_vld)
  , .rd_rdy_i    (rd_rdy)
  );

  link_tx #(
    .CC_INTERVAL (CC_INTERVAL)
  ) u_link_tx (
    .clk_i       (clk_i)
  , .rst_n_i     (rst_n_i)
  , .rd_data_i   (rd_data)
  , .rd_kflags_i (rd_kflags)
  , .rd_vld_i    (rd_vld)
  , .rd_rdy_o    (rd_rdy)
  , .txdata_o    (txdata_o)
  , .txcharisk_o (txcharisk_o)
  );

endmodule

// File: link_tx.sv
`timescale 1ns/1ns

module link_tx
  import mux_link_pkg::*;
#(
  parameter int CC_INTERVAL = 64
)
(
  input  logic                  clk_i
, input  logic                  rst_n_i
  // From the frame FIFO
, input  link_word_u            rd_data_i
, input  logic [LINK_BYTES-1:0] rd_kflags_i
, input  logic                  rd_vld_i
, output logic                  rd_rdy_o
  // Serial transmitter, one word per cycle
, output logic [LINK_BITS-1:0]  txdata_o
, output logic [LINK_BYTES-1:0] txcharisk_o
);

  localparam int CC_BITS = (CC_INTERVAL > 1) ? $clog2(CC_INTERVAL) : 1;

  logic [CC_BITS-1:0]    cc_cnt_q;
  logic                  cc_slot;
  link_word_u            idle_word;
  link_word_u            cc_word;
  link_word_u            nxt_word;
  logic [LINK_BYTES-1:0] nxt_kflags;

  //////////////////////////////
  // Clock-correction schedule
  //////////////////////////////

  assign cc_slot = (cc_cnt_q == CC_BITS'(CC_INTERVAL - 1));

  // FIFO is not popped in a CC slot
  assign rd_rdy_o = !cc_slot;

  //////////////////////////////
  // Word selection
  //////////////////////////////

  always_comb begin
    idle_word.ctrl.kchar                      = K_COMMA;
    {idle_word.ctrl.fill, idle_word.ctrl.chan} = IDLE_FILL;
    cc_word.ctrl.kchar                        = K_CC;
    {cc_word.ctrl.fill, cc_word.ctrl.chan}     = IDLE_FILL;
  end

  // CC first, then data, else idle
  always_comb begin
    nxt_word   = idle_word;
    nxt_kflags = CTRL_KFLAGS;
    if (cc_slot) begin
      nxt_word = cc_word;
    end else if (rd_vld_i) begin
      nxt_word   = rd_data_i;
      nxt_kflags = rd_kflags_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cc_cnt_q    <= '0;
      txdata_o    <= idle_word.payload;
      txcharisk_o <= CTRL_KFLAGS;
    end else begin
      cc_cnt_q    <= cc_slot ? '0 : cc_cnt_q + 1'b1;
      txdata_o    <= nxt_word.payload;
      txcharisk_o <= nxt_kflags;
    end
  end

endmodule

// File: list.f
mux_link_pkg.sv
mux_pkt_pkg.sv
pkt_assembler.sv
frame_fifo.sv
link_tx.sv
hss_mux_top.sv
hss_mux_sva.sv
tb_hss_mux.sv

// File: mux_link_pkg.sv
package mux_link_pkg;

  //////////////////////////////
  // Link word geometry
  //////////////////////////////

  localparam int LINK_BITS  = 32;
  // One K flag per byte
  localparam int LINK_BYTES = LINK_BITS / 8;

  //////////////////////////////
  // 8b/10b K-characters
  //////////////////////////////

  // K27.7, start of frame
  localparam logic [7:0] K_SOF   = 8'hFB;
  // K28.5, carries the comma for word alignment
  localparam logic [7:0] K_COMMA = 8'hBC;
  // K23.7, dropped or repeated by the receiver's elastic buffer
  localparam logic [7:0] K_CC    = 8'hF7;

  // D21.5 pattern behind the comma
  localparam logic [23:0] IDLE_FILL = 24'hB5_B5_B5;

  // Control words flag byte 0 only
  localparam logic [LINK_BYTES-1:0] CTRL_KFLAGS = 4'b0001;

  // Declared high byte first, so kchar lands in byte 0
  typedef struct packed {
    logic [15:0] fill;
    logic [7:0]  chan;
    logic [7:0]  kchar;
  } link_ctrl_t;

  typedef union packed {
    link_ctrl_t           ctrl;
    logic [LINK_BITS-1:0] payload;
  } link_word_u;

endpackage

// File: mux_pkt_pkg.sv
package mux_pkt_pkg;

  //////////////////////////////
  // Packet streams
  //////////////////////////////

  // Width of one packet on a stream input
  localparam int PKT_BITS = 32;

  // Channel number as carried in the header
  localparam int CHAN_BITS = 3;

  // Highest channel count the header can address
  localparam int MAX_CHANS = 1 << CHAN_BITS;

endpackage

// File: pkt_assembler.sv
`timescale 1ns/1ns

module pkt_assembler
  import mux_pkt_pkg::*;
  import mux_link_pkg::*;
#(
  parameter int NUM_CHANS = 4
)
(
  input  logic                               clk_i
, input  logic                               rst_n_i
  // Packet streams
, input  logic [NUM_CHANS-1:0][PKT_BITS-1:0] pkt_data_i
, input  logic [NUM_CHANS-1:0]               pkt_vld_i
, output logic [NUM_CHANS-1:0]               pkt_rdy_o
  // Towards the frame FIFO
, output link_word_u                         wr_data_o
, output logic [LINK_BYTES-1:0]              wr_kflags_o
, output logic                               wr_vld_o
, input  logic                               wr_rdy_i
);

  logic [CHAN_BITS-1:0] last_q;
  logic                 phase_q;
  logic                 armed_q;
  logic [PKT_BITS-1:0]  payload_q;
  logic                 grant_found;
  logic [CHAN_BITS-1:0] grant_chan;
  logic                 offer;
  logic                 accept;

  if (NUM_CHANS < 1 || NUM_CHANS > MAX_CHANS) begin : g_bad_num_chans
    $error("pkt_assembler: NUM_CHANS must lie in 1..MAX_CHANS");
  end

  //////////////////////////////
  // Round-robin grant
  //////////////////////////////

  // Search starts one past the last channel served
  always_comb begin
    int cand;
    grant_found = 1'b0;
    grant_chan  = '0;
    for (int i = 1; i <= NUM_CHANS; i++) begin
      cand = (int'(last_q) + i) % NUM_CHANS;
      if (!grant_found && pkt_vld_i[cand]) begin
        grant_found = 1'b1;
        grant_chan  = CHAN_BITS'(cand);
      end
    end
  end

  // Header phase only, and only once out of reset
  assign offer  = armed_q && !phase_q && grant_found;
  assign accept = offer && wr_rdy_i;

  always_comb begin
    for (int c = 0; c < NUM_CHANS; c++) begin
      pkt_rdy_o[c] = accept && (grant_chan == CHAN_BITS'(c));
    end
  end

  //////////////////////////////
  // Word output
  //////////////////////////////

  assign wr_vld_o = phase_q || offer;

  always_comb begin
    wr_data_o.payload = payload_q;
    wr_kflags_o       = '0;
    if (!phase_q) begin
      wr_data_o.ctrl.kchar = K_SOF;
      wr_data_o.ctrl.chan  = 8'(grant_chan);
      wr_data_o.ctrl.fill  = '0;
      wr_kflags_o          = CTRL_KFLAGS;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      last_q  <= CHAN_BITS'(NUM_CHANS - 1);
      phase_q <= 1'b0;
      armed_q <= 1'b0;
    end else begin
      armed_q <= 1'b1;
      if (accept) begin
        last_q  <= grant_chan;
        phase_q <= 1'b1;
      end else if (phase_q && wr_rdy_i) begin
        // Payload taken, back to header phase
        phase_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      payload_q <= pkt_data_i[grant_chan];
    end
  end

endmodule

// File: tb_hss_mux.sv
`timescale 1ns/1ns

module tb_hss_mux
  import mux_pkt_pkg::*;
  import mux_link_pkg::*;
();

  localparam int NUM_CHANS   = 4;
  localparam int FIFO_DEPTH  = 8;
  localparam int CC_INTERVAL = 64;
  localparam int SEED        = 92;
  localparam int STALL_LIMIT = 200;
  localparam int DRAIN_LIMIT = 1000;

  localparam int MODE_OFF    = 0;
  localparam int MODE_RAND   = 1;
  localparam int MODE_ALL    = 2;
  localparam int MODE_SPARSE = 3;

  logic                               clk;
  logic                               rst_n;
  logic [NUM_CHANS-1:0][PKT_BITS-1:0] pkt_data;
  logic [NUM_CHANS-1:0]               pkt_vld;
  logic [NUM_CHANS-1:0]               pkt_rdy;
  logic [LINK_BITS-1:0]               txdata;
  logic [LINK_BYTES-1:0]              txcharisk;

  logic [PKT_BITS-1:0] exp_q [NUM_CHANS][$];
  logic [NUM_CHANS-1:0] fire;
  int                   stall [NUM_CHANS];
  int                   mode;
  int                   cyc;
  int                   payloads;
  bit                   hdr_open;
  int                   hdr_chan;
  bit                   rr_have;
  int                   rr_last;

  hss_mux_top #(
    .NUM_CHANS   (NUM_CHANS)
  , .FIFO_DEPTH  (FIFO_DEPTH)
  , .CC_INTERVAL (CC_INTERVAL)
  ) DUT (
    .clk_i       (clk)
  , .rst_n_i     (rst_n)
  , .pkt_data_i  (pkt_data)
  , .pkt_vld_i   (pkt_vld)
  , .pkt_rdy_o   (pkt_rdy)
  , .txdata_o    (txdata)
  , .txcharisk_o (txcharisk)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Test failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  // Edges since reset release, CC due on every multiple of CC_INTERVAL
  always @(posedge clk) begin
    if (rst_n) begin
      cyc <= cyc + 1;
    end
  end

  //////////////////////////////
  // Handshake capture and link monitor
  //////////////////////////////

  always @(negedge clk) begin
    link_word_u w;
    logic [PKT_BITS-1:0] exp_word;
    bit is_cc;
    for (int c = 0; c < NUM_CHANS; c++) begin
      fire[c] = rst_n && pkt_vld[c] && pkt_rdy[c];
      if (fire[c]) begin
        exp_q[c].push_back(pkt_data[c]);
        if (mode == MODE_ALL) begin
          // FIFO keeps order, so accept order is header order
          if (rr_have) begin
            assert (c == (rr_last + 1) % NUM_CHANS)
              else abort_run($sformatf("Fail %0t: round-robin gave chan %0d after %0d",
                                       $time, c, rr_last));
          end
          rr_have = 1'b1;
          rr_last = c;
        end
      end
    end
    if (mode != MODE_ALL) begin
      rr_have = 1'b0;
    end
    w.payload = txdata;
    if (txcharisk == '0) begin
      assert (hdr_open)
        else abort_run($sformatf("Fail %0t: payload word without header", $time));
      assert (exp_q[hdr_chan].size() > 0)
        else abort_run($sformatf("Fail %0t: payload on chan %0d with nothing queued",
                                 $time, hdr_chan));
      exp_word = exp_q[hdr_chan].pop_front();
      assert (txdata == exp_word)
        else abort_run($sformatf("Fail %0t: chan %0d payload %h, expected %h",
                                 $time, hdr_chan, txdata, exp_word));
      hdr_open = 1'b0;
      payloads++;
    end else begin
      assert (txcharisk == CTRL_KFLAGS)
        else abort_run($sformatf("Fail %0t: bad K flags %b", $time, txcharisk));
      is_cc = (w.ctrl.kchar == K_CC);
      assert (is_cc == (cyc > 0 && cyc % CC_INTERVAL == 0))
        else abort_run($sformatf("Fail %0t: CC word %0d at cycle %0d", $time, is_cc, cyc));
      if (is_cc) begin
        assert (txdata == {IDLE_FILL, K_CC})
          else abort_run($sformatf("Fail %0t: malformed CC word %h", $time, txdata));
      end else if (w.ctrl.kchar == K_SOF) begin
        assert (!hdr_open)
          else abort_run($sformatf("Fail %0t: header while payload pending", $time));
        assert (w.ctrl.chan < NUM_CHANS && w.ctrl.fill == '0)
          else abort_run($sformatf("Fail %0t: bad header %h", $time, txdata));
        hdr_open = 1'b1;
        hdr_chan = int'(w.ctrl.chan);
      end else begin
        assert (txdata == {IDLE_FILL, K_COMMA})
          else abort_run($sformatf("Fail %0t: expected idle, got %h", $time, txdata));
      end
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  function automatic logic want_valid();
    case (mode)
      MODE_RAND:   return ($urandom % 2) == 0;
      MODE_ALL:    return 1'b1;
      MODE_SPARSE: return ($urandom % 16) == 0;
      default:     return 1'b0;
    endcase
  endfunction

  // Data held until the handshake, then a fresh draw
  task automatic drive_streams();
    for (int c = 0; c < NUM_CHANS; c++) begin
      if (fire[c] || !pkt_vld[c]) begin
        pkt_vld[c]  = want_valid();
        pkt_data[c] = $urandom;
        stall[c]    = 0;
      end else begin
        stall[c]++;
        if (stall[c] > STALL_LIMIT) begin
          abort_run($sformatf("Timeout: channel %0d waited too long for ready", c));
        end
      end
    end
  endtask

  task automatic run_phase(input int m, input int cycles);
    mode = m;
    repeat (cycles) begin
      @(posedge clk);
      #2;
      drive_streams();
    end
  endtask

  function automatic bit queues_empty();
    for (int c = 0; c < NUM_CHANS; c++) begin
      if (exp_q[c].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  initial begin
    int wait_cnt;
    void'($urandom(SEED));
    rst_n    = 1'b0;
    pkt_vld  = '0;
    pkt_data = '0;
    fire     = '0;
    mode     = MODE_OFF;
    cyc      = 0;
    payloads = 0;
    hdr_open = 1'b0;
    hdr_chan = 0;
    rr_have  = 1'b0;
    rr_last  = 0;
    for (int c = 0; c < NUM_CHANS; c++) begin
      stall[c] = 0;
    end
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    run_phase(MODE_OFF, 10);
    run_phase(MODE_RAND, 300);
    // Long enough for CC slots to fill the FIFO and push back
    run_phase(MODE_ALL, 700);
    run_phase(MODE_SPARSE, 300);
    // Drain whatever is still queued
    mode     = MODE_OFF;
    wait_cnt = 0;
    while (pkt_vld != '0 || !queues_empty() || hdr_open) begin
      @(posedge clk);
      #2;
      drive_streams();
      wait_cnt++;
      if (wait_cnt > DRAIN_LIMIT) begin
        abort_run("Timeout: link did not drain the queued packets");
      end
    end
    if (payloads > 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
